/* Bender.yml */
package:
  name: periph_soc

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/soc_pkg.sv
      - src/sys_bus.sv
      - src/data_ram.sv
      - src/timer.sv
      - src/gpio.sv
      - src/periph_soc.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/clk_gen.sv
      - verif/periph_soc_tb.sv

/* periph_soc.f */
+incdir+src
src/soc_pkg.sv
src/sys_bus.sv
src/data_ram.sv
src/timer.sv
src/gpio.sv
src/periph_soc.sv
verif/clk_gen.sv
verif/periph_soc_tb.sv

/* src/data_ram.sv */
// --------------------------------------------------
// contents undefined after reset
// upper address bits above bit 9 are ignored
// --------------------------------------------------
`timescale 1ns/1ns
`include "soc_config.svh"

module data_ram (
    input  logic                 clk,
    input  soc_pkg::slv_req_t    ram_req_i,
    output logic [`SOC_XLEN-1:0] rdata_o
);
    import soc_pkg::*;

    logic [`SOC_XLEN-1:0]   mem [`SOC_RAM_WORDS];
    logic [`SOC_RAM_AW-1:0] word_addr;

    // word index from the byte address
    assign word_addr = ram_req_i.addr[`SOC_RAM_AW+1:2];

    always_ff @(posedge clk) begin
        if (ram_req_i.sel) begin
            if (ram_req_i.we) begin
                mem[word_addr] <= ram_req_i.wdata;
            end else begin
                // registered read port, block RAM style
                rdata_o <= mem[word_addr];
            end
        end
    end

endmodule

/* src/gpio.sv */
// --------------------------------------------------
// mode 01 output, 10 input, others idle; no pads here,
// pins_i is sampled without a synchronizer
// --------------------------------------------------
`timescale 1ns/1ns
`include "soc_config.svh"

module gpio (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  soc_pkg::slv_req_t         gpio_req_i,
    output logic [`SOC_XLEN-1:0]      rdata_o,
    input  logic [`SOC_GPIO_PINS-1:0] pins_i,
    output logic [`SOC_GPIO_PINS-1:0] pins_o,
    output logic [`SOC_GPIO_PINS-1:0] pins_oe_o
);
    import soc_pkg::*;

    logic [2*`SOC_GPIO_PINS-1:0] ctrl_q;
    logic [`SOC_GPIO_PINS-1:0]   data_q;
    logic [`SOC_GPIO_PINS-1:0]   data_d;
    logic [`SOC_GPIO_PINS-1:0]   out_mask;
    logic [`SOC_GPIO_PINS-1:0]   in_mask;
    gpio_reg_e                   reg_sel;
    logic                        reg_wr;
    logic                        reg_rd;

    assign reg_sel = gpio_reg_e'(gpio_req_i.addr[3:2]);
    assign reg_wr  = gpio_req_i.sel && gpio_req_i.we;
    assign reg_rd  = gpio_req_i.sel && !gpio_req_i.we;

    // per-pin mode decode
    always_comb begin
        for (int i = 0; i < `SOC_GPIO_PINS; i++) begin
            out_mask[i] = (ctrl_q[2*i +: 2] == 2'b01);
            in_mask[i]  = (ctrl_q[2*i +: 2] == 2'b10);
        end
    end

    // bus write first, then input pins overwrite their bits
    always_comb begin
        data_d = data_q;
        if (reg_wr && reg_sel == GPIO_DATA) begin
            data_d = gpio_req_i.wdata[`SOC_GPIO_PINS-1:0];
        end
        data_d = (data_d & ~in_mask) | (pins_i & in_mask);
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
            data_q <= '0;
        end else begin
            if (reg_wr && reg_sel == GPIO_CTRL) begin
                ctrl_q <= gpio_req_i.wdata[2*`SOC_GPIO_PINS-1:0];
            end
            data_q <= data_d;
        end
    end

    // read port, one cycle latency
    always_ff @(posedge clk) begin
        if (reg_rd) begin
            case (reg_sel)
                GPIO_CTRL: rdata_o <= `SOC_XLEN'(ctrl_q);
                GPIO_DATA: rdata_o <= `SOC_XLEN'(data_q);
                default:   rdata_o <= '0;
            endcase
        end
    end

    assign pins_o    = data_q;
    assign pins_oe_o = out_mask;

endmodule

/* src/periph_soc.sv */
// --------------------------------------------------
// core and debug are external master ports
// gpio is split into in, out and output enable
// --------------------------------------------------
`timescale 1ns/1ns
`include "soc_config.svh"

module periph_soc (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  soc_pkg::bus_req_t         core_req_i,
    input  soc_pkg::bus_req_t         dbg_req_i,
    output soc_pkg::bus_rsp_t         core_rsp_o,
    output soc_pkg::bus_rsp_t         dbg_rsp_o,
    output logic                      core_hold_o,
    output logic                      irq_o,
    input  logic [`SOC_GPIO_PINS-1:0] gpio_i,
    output logic [`SOC_GPIO_PINS-1:0] gpio_o,
    output logic [`SOC_GPIO_PINS-1:0] gpio_oe_o
);
    import soc_pkg::*;

    // --------------------------------------------------
    // slave side of the bus
    // --------------------------------------------------
    slv_req_t             ram_req;
    slv_req_t             timer_req;
    slv_req_t             gpio_req;
    logic [`SOC_XLEN-1:0] ram_rdata;
    logic [`SOC_XLEN-1:0] timer_rdata;
    logic [`SOC_XLEN-1:0] gpio_rdata;

    sys_bus u_sys_bus (
        .clk           ( clk         ),
        .rst_n_i       ( rst_n_i     ),
        .core_req_i    ( core_req_i  ),
        .dbg_req_i     ( dbg_req_i   ),
        .core_rsp_o    ( core_rsp_o  ),
        .dbg_rsp_o     ( dbg_rsp_o   ),
        .core_hold_o   ( core_hold_o ),
        .ram_req_o     ( ram_req     ),
        .timer_req_o   ( timer_req   ),
        .gpio_req_o    ( gpio_req    ),
        .ram_rdata_i   ( ram_rdata   ),
        .timer_rdata_i ( timer_rdata ),
        .gpio_rdata_i  ( gpio_rdata  )
    );

    data_ram u_data_ram (
        .clk       ( clk       ),
        .ram_req_i ( ram_req   ),
        .rdata_o   ( ram_rdata )
    );

    // single interrupt source for now
    timer u_timer (
        .clk         ( clk         ),
        .rst_n_i     ( rst_n_i     ),
        .timer_req_i ( timer_req   ),
        .rdata_o     ( timer_rdata ),
        .irq_o       ( irq_o       )
    );

    gpio u_gpio (
        .clk        ( clk        ),
        .rst_n_i    ( rst_n_i    ),
        .gpio_req_i ( gpio_req   ),
        .rdata_o    ( gpio_rdata ),
        .pins_i     ( gpio_i     ),
        .pins_o     ( gpio_o     ),
        .pins_oe_o  ( gpio_oe_o  )
    );

endmodule

/* src/soc_config.svh */
// --------------------------------------------------
// fixed widths and address map; the region code is
// compared against address bits 31:28 only
// --------------------------------------------------
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// data and address width
`define SOC_XLEN        32

// data RAM depth in words and its word index width
`define SOC_RAM_WORDS   256
`define SOC_RAM_AW      8

// number of GPIO pins, two mode bits each
`define SOC_GPIO_PINS   16

// --------------------------------------------------
// region codes, address bits 31:28
// --------------------------------------------------
`define SOC_RAM_BASE    4'h1
`define SOC_TIMER_BASE  4'h2
`define SOC_GPIO_BASE   4'h3

`endif

/* src/soc_pkg.sv */
// --------------------------------------------------
// bus structs and register offset encodings
// --------------------------------------------------
`include "soc_config.svh"

package soc_pkg;

    // master request, held stable while req is high
    typedef struct packed {
        logic                 req;
        logic                 we;
        logic [`SOC_XLEN-1:0] addr;
        logic [`SOC_XLEN-1:0] wdata;
    } bus_req_t;

    // rvalid pulses one cycle with the read word
    typedef struct packed {
        logic                 rvalid;
        logic [`SOC_XLEN-1:0] rdata;
    } bus_rsp_t;

    // request as one slave sees it, sel already decoded
    typedef struct packed {
        logic                 sel;
        logic                 we;
        logic [`SOC_XLEN-1:0] addr;
        logic [`SOC_XLEN-1:0] wdata;
    } slv_req_t;

    typedef enum logic [1:0] {
        SLV_RAM,
        SLV_TIMER,
        SLV_GPIO,
        SLV_NONE
    } slave_e;

    // timer offsets, address bits 3:2
    typedef enum logic [1:0] {
        TMR_CTRL  = 2'd0,
        TMR_COUNT = 2'd1,
        TMR_VALUE = 2'd2
    } timer_reg_e;

    // gpio offsets, address bits 3:2
    typedef enum logic [1:0] {
        GPIO_CTRL = 2'd0,
        GPIO_DATA = 2'd1
    } gpio_reg_e;

endpackage

/* src/sys_bus.sv */
// --------------------------------------------------
// debug port always wins; core is held meanwhile
// slaves must answer reads exactly one cycle later
// --------------------------------------------------
`timescale 1ns/1ns
`include "soc_config.svh"

module sys_bus (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  soc_pkg::bus_req_t    core_req_i,
    input  soc_pkg::bus_req_t    dbg_req_i,
    output soc_pkg::bus_rsp_t    core_rsp_o,
    output soc_pkg::bus_rsp_t    dbg_rsp_o,
    output logic                 core_hold_o,
    output soc_pkg::slv_req_t    ram_req_o,
    output soc_pkg::slv_req_t    timer_req_o,
    output soc_pkg::slv_req_t    gpio_req_o,
    input  logic [`SOC_XLEN-1:0] ram_rdata_i,
    input  logic [`SOC_XLEN-1:0] timer_rdata_i,
    input  logic [`SOC_XLEN-1:0] gpio_rdata_i
);
    import soc_pkg::*;

    bus_req_t             grant_req;
    logic                 grant_dbg;
    slave_e               target;
    logic                 rd_valid_q;
    logic                 rd_dbg_q;
    slave_e               rd_target_q;
    logic [`SOC_XLEN-1:0] rd_word;

    // build the request seen by one slave
    function automatic slv_req_t to_slave(bus_req_t req, logic hit);
        slv_req_t s;
        s.sel   = req.req && hit;
        s.we    = req.we;
        s.addr  = req.addr;
        s.wdata = req.wdata;
        return s;
    endfunction

    // --------------------------------------------------
    // arbitration and decode
    // --------------------------------------------------
    assign grant_dbg   = dbg_req_i.req;
    assign grant_req   = grant_dbg ? dbg_req_i : core_req_i;
    assign core_hold_o = dbg_req_i.req;

    always_comb begin
        case (grant_req.addr[`SOC_XLEN-1:`SOC_XLEN-4])
            `SOC_RAM_BASE:   target = SLV_RAM;
            `SOC_TIMER_BASE: target = SLV_TIMER;
            `SOC_GPIO_BASE:  target = SLV_GPIO;
            default:         target = SLV_NONE;
        endcase
    end

    // unmapped writes simply get no sel
    assign ram_req_o   = to_slave(grant_req, target == SLV_RAM);
    assign timer_req_o = to_slave(grant_req, target == SLV_TIMER);
    assign gpio_req_o  = to_slave(grant_req, target == SLV_GPIO);

    // --------------------------------------------------
    // read return routing
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_valid_q  <= 1'b0;
            rd_dbg_q    <= 1'b0;
            rd_target_q <= SLV_NONE;
        end else begin
            rd_valid_q  <= grant_req.req && !grant_req.we;
            rd_dbg_q    <= grant_dbg;
            rd_target_q <= target;
        end
    end

    always_comb begin
        case (rd_target_q)
            SLV_RAM:   rd_word = ram_rdata_i;
            SLV_TIMER: rd_word = timer_rdata_i;
            SLV_GPIO:  rd_word = gpio_rdata_i;
            default:   rd_word = '0;
        endcase
    end

    // both masters see the word, only the winner gets rvalid
    assign core_rsp_o = '{rvalid: rd_valid_q && !rd_dbg_q, rdata: rd_word};
    assign dbg_rsp_o  = '{rvalid: rd_valid_q && rd_dbg_q, rdata: rd_word};

endmodule

/* src/timer.sv */
// --------------------------------------------------
// count wraps to zero after matching the compare value
// pending is cleared by writing 1 to ctrl bit 2
// --------------------------------------------------
`timescale 1ns/1ns
`include "soc_config.svh"

module timer (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  soc_pkg::slv_req_t    timer_req_i,
    output logic [`SOC_XLEN-1:0] rdata_o,
    output logic                 irq_o
);
    import soc_pkg::*;

    logic                 enable_q;
    logic                 irq_en_q;
    logic                 pending_q;
    logic [`SOC_XLEN-1:0] count_q;
    logic [`SOC_XLEN-1:0] value_q;
    timer_reg_e           reg_sel;
    logic                 reg_wr;
    logic                 reg_rd;
    logic                 hit;

    assign reg_sel = timer_reg_e'(timer_req_i.addr[3:2]);
    assign reg_wr  = timer_req_i.sel && timer_req_i.we;
    assign reg_rd  = timer_req_i.sel && !timer_req_i.we;
    assign hit     = enable_q && (count_q == value_q);
    assign irq_o   = pending_q && irq_en_q;

    // --------------------------------------------------
    // control, compare and counter
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            enable_q  <= 1'b0;
            irq_en_q  <= 1'b0;
            pending_q <= 1'b0;
            count_q   <= '0;
            value_q   <= '0;
        end else begin
            if (enable_q) begin
                count_q <= hit ? '0 : count_q + 1'b1;
            end
            if (reg_wr && reg_sel == TMR_CTRL) begin
                enable_q <= timer_req_i.wdata[0];
                irq_en_q <= timer_req_i.wdata[1];
            end
            if (reg_wr && reg_sel == TMR_VALUE) begin
                value_q <= timer_req_i.wdata;
            end
            // a new match wins over a clear in the same cycle
            if (hit) begin
                pending_q <= 1'b1;
            end else if (reg_wr && reg_sel == TMR_CTRL && timer_req_i.wdata[2]) begin
                pending_q <= 1'b0;
            end
        end
    end

    // read port, one cycle latency
    always_ff @(posedge clk) begin
        if (reg_rd) begin
            case (reg_sel)
                TMR_CTRL:  rdata_o <= {{(`SOC_XLEN-3){1'b0}}, pending_q, irq_en_q, enable_q};
                TMR_COUNT: rdata_o <= count_q;
                TMR_VALUE: rdata_o <= value_q;
                default:   rdata_o <= '0;
            endcase
        end
    end

endmodule

/* verif/clk_gen.sv */
// --------------------------------------------------
// free-running 20 ns clock, reset low for 4 edges
// --------------------------------------------------
`timescale 1ns/1ns

module clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // reset released on the 4th rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

/* verif/periph_soc_tb.sv */
// --------------------------------------------------
// directed tests through the core and debug ports
// gpio pins loop back wherever output enable is set
// --------------------------------------------------
`timescale 1ns/1ns
`include "soc_config.svh"

module periph_soc_tb;
    import soc_pkg::*;

    localparam int TIMER_N         = 20;
    // worst-case cycles per test, used by the watchdog
    localparam int RESET_CYCLES    = 12;
    localparam int RAM_CYCLES      = 32 * 3 + 64 * 4;
    localparam int ARB_CYCLES      = 16;
    localparam int UNMAP_CYCLES    = 12 * 4;
    localparam int TIMER_CYCLES    = 2 * TIMER_N + 40;
    localparam int GPIO_CYCLES     = 20;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + RAM_CYCLES + ARB_CYCLES + UNMAP_CYCLES
                                     + TIMER_CYCLES + GPIO_CYCLES + 100;

    logic                      clk;
    logic                      rst_n;
    bus_req_t                  core_req;
    bus_req_t                  dbg_req;
    bus_rsp_t                  core_rsp;
    bus_rsp_t                  dbg_rsp;
    logic                      core_hold;
    logic                      irq;
    logic [`SOC_GPIO_PINS-1:0] gpio_in;
    logic [`SOC_GPIO_PINS-1:0] gpio_out;
    logic [`SOC_GPIO_PINS-1:0] gpio_oe;
    logic [`SOC_GPIO_PINS-1:0] pin_pattern;
    logic [31:0]               rng_state = 32'hb6b;
    int                        cycle = 0;
    int                        fail_count = 0;
    int                        fails_at_start = 0;
    int                        tests_run = 0;
    int                        tests_failed = 0;

    clk_gen u_clk_gen (
        .clk_o   ( clk   ),
        .rst_n_o ( rst_n )
    );

    periph_soc dut_i (
        .clk         ( clk       ),
        .rst_n_i     ( rst_n     ),
        .core_req_i  ( core_req  ),
        .dbg_req_i   ( dbg_req   ),
        .core_rsp_o  ( core_rsp  ),
        .dbg_rsp_o   ( dbg_rsp   ),
        .core_hold_o ( core_hold ),
        .irq_o       ( irq       ),
        .gpio_i      ( gpio_in   ),
        .gpio_o      ( gpio_out  ),
        .gpio_oe_o   ( gpio_oe   )
    );

    // driven pins come back, the rest follow the pattern
    assign gpio_in = (gpio_out & gpio_oe) | (pin_pattern & ~gpio_oe);

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic bus_req_t make_req(logic we, logic [31:0] addr, logic [31:0] wdata);
        bus_req_t r;
        r.req   = 1'b1;
        r.we    = we;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    // region in bits 31:28, word index from bit 2
    function automatic logic [31:0] addr_of(logic [3:0] region, logic [7:0] word);
        return {region, 18'h0, word, 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            fail_count++;
        end
    endtask

    task automatic start_test();
        fails_at_start = fail_count;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (fail_count == fails_at_start) begin
            $display("test %-16s passed", name);
        end else begin
            tests_failed++;
            $display("test %-16s %0d mismatches", name, fail_count - fails_at_start);
        end
    endtask

    // hold the request until the edge that takes it
    task automatic drive_request(input bit use_dbg, input bus_req_t r, output int taken_at);
        bit taken;
        taken    = 1'b0;
        taken_at = 0;
        @(posedge clk);
        if (use_dbg) begin
            dbg_req <= r;
        end else begin
            core_req <= r;
        end
        while (!taken) begin
            @(negedge clk);
            if (use_dbg) begin
                check_value("core_hold_o", 32'h1, {31'h0, core_hold});
                taken = 1'b1;
            end else begin
                taken = !core_hold;
            end
            taken_at = cycle;
            @(posedge clk);
        end
        if (use_dbg) begin
            dbg_req <= '0;
        end else begin
            core_req <= '0;
        end
    endtask

    task automatic bus_write(input bit use_dbg, input logic [31:0] addr,
                             input logic [31:0] data, output int taken_at);
        drive_request(use_dbg, make_req(1'b1, addr, data), taken_at);
    endtask

    task automatic bus_read(input bit use_dbg, input logic [31:0] addr,
                            output logic [31:0] data);
        bus_rsp_t rsp;
        int       waited;
        int       taken_at;
        drive_request(use_dbg, make_req(1'b0, addr, 32'h0), taken_at);
        waited = 0;
        rsp    = '0;
        while (!rsp.rvalid && waited < 4) begin
            @(negedge clk);
            waited++;
            rsp = use_dbg ? dbg_rsp : core_rsp;
        end
        assert (rsp.rvalid && waited == 1) else begin
            if (!rsp.rvalid) begin
                $display("read of %h got no rvalid within 4 cycles", addr);
            end else begin
                $display("read of %h got rvalid %0d cycles late", addr, waited - 1);
            end
            fail_count++;
        end
        data = rsp.rdata;
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic reset_state();
        logic [31:0] d;
        start_test();
        @(negedge clk);
        check_value("core_rsp_o.rvalid", 32'h0, {31'h0, core_rsp.rvalid});
        check_value("dbg_rsp_o.rvalid", 32'h0, {31'h0, dbg_rsp.rvalid});
        check_value("core_hold_o", 32'h0, {31'h0, core_hold});
        check_value("irq_o", 32'h0, {31'h0, irq});
        check_value("gpio_oe_o", 32'h0, {16'h0, gpio_oe});
        bus_read(1'b0, addr_of(`SOC_TIMER_BASE, TMR_COUNT), d);
        check_value("timer count", 32'h0, d);
        finish_test("reset_state");
    endtask

    task automatic ram_write_read();
        logic [31:0] model [256];
        logic [7:0]  idx_list [32];
        logic [31:0] rnd;
        logic [31:0] d;
        int          t;
        start_test();
        for (int i = 0; i < 32; i++) begin
            rnd         = next_random();
            idx_list[i] = rnd[7:0];
            d           = next_random();
            model[idx_list[i]] = d;
            bus_write(1'b0, addr_of(`SOC_RAM_BASE, idx_list[i]), d, t);
        end
        for (int i = 0; i < 32; i++) begin
            bus_read(1'b0, addr_of(`SOC_RAM_BASE, idx_list[i]), d);
            check_value("core_rsp_o.rdata", model[idx_list[i]], d);
            bus_read(1'b1, addr_of(`SOC_RAM_BASE, idx_list[i]), d);
            check_value("dbg_rsp_o.rdata", model[idx_list[i]], d);
        end
        finish_test("ram_write_read");
    endtask

    task automatic arbitration_hold();
        logic [31:0] a;
        logic [31:0] d_dbg;
        logic [31:0] d_core;
        logic [31:0] d;
        int          t_dbg;
        int          t_core;
        start_test();
        a      = addr_of(`SOC_RAM_BASE, 8'h40);
        d_dbg  = next_random();
        d_core = next_random();
        // both ports request on the same edge
        fork
            bus_write(1'b1, a, d_dbg, t_dbg);
            bus_write(1'b0, a, d_core, t_core);
        join
        assert (t_dbg < t_core) else begin
            $display("held core write was taken before the debug write");
            fail_count++;
        end
        bus_read(1'b1, a, d);
        check_value("dbg_rsp_o.rdata", d_core, d);
        finish_test("arbitration_hold");
    endtask

    task automatic unmapped_region();
        logic [31:0] regs [3];
        logic [31:0] addrs [3];
        logic [31:0] d;
        int          t;
        start_test();
        addrs[0] = addr_of(`SOC_RAM_BASE, 8'h05);
        addrs[1] = addr_of(`SOC_TIMER_BASE, TMR_VALUE);
        addrs[2] = addr_of(`SOC_GPIO_BASE, GPIO_CTRL);
        bus_write(1'b0, addrs[0], next_random(), t);
        for (int i = 0; i < 3; i++) begin
            bus_read(1'b0, addrs[i], regs[i]);
        end
        bus_read(1'b0, addr_of(4'hf, 8'h00), d);
        check_value("core_rsp_o.rdata", 32'h0, d);
        // same offsets as the real registers, region 0xf
        for (int i = 0; i < 3; i++) begin
            bus_write(1'b0, {4'hf, addrs[i][27:0]}, next_random(), t);
        end
        for (int i = 0; i < 3; i++) begin
            bus_read(1'b0, addrs[i], d);
            check_value("core_rsp_o.rdata", regs[i], d);
        end
        finish_test("unmapped_region");
    endtask

    task automatic timer_irq();
        logic [31:0] d;
        int          t;
        int          k;
        bit          fired;
        start_test();
        bus_write(1'b0, addr_of(`SOC_TIMER_BASE, TMR_VALUE), TIMER_N, t);
        bus_write(1'b0, addr_of(`SOC_TIMER_BASE, TMR_CTRL), 32'h3, t);
        k     = 0;
        fired = 1'b0;
        while (!fired && k < TIMER_N + 2) begin
            @(negedge clk);
            k++;
            fired = irq;
        end
        assert (fired) else begin
            $display("irq_o did not rise within %0d cycles", TIMER_N + 2);
            fail_count++;
        end
        bus_read(1'b0, addr_of(`SOC_TIMER_BASE, TMR_CTRL), d);
        check_value("timer ctrl", 32'h7, d);
        // clear pending and stop with irq enable still set
        bus_write(1'b0, addr_of(`SOC_TIMER_BASE, TMR_CTRL), 32'h6, t);
        @(negedge clk);
        check_value("irq_o", 32'h0, {31'h0, irq});
        // count resumes from where it stopped, irq stays masked
        bus_write(1'b0, addr_of(`SOC_TIMER_BASE, TMR_CTRL), 32'h1, t);
        repeat (TIMER_N + 3) begin
            @(negedge clk);
            check_value("irq_o", 32'h0, {31'h0, irq});
        end
        bus_read(1'b0, addr_of(`SOC_TIMER_BASE, TMR_CTRL), d);
        check_value("timer ctrl", 32'h5, d);
        bus_write(1'b0, addr_of(`SOC_TIMER_BASE, TMR_CTRL), 32'h4, t);
        finish_test("timer_irq");
    endtask

    task automatic gpio_loopback();
        logic [31:0]               rnd;
        logic [31:0]               ctrl;
        logic [31:0]               wdata;
        logic [31:0]               d;
        logic [`SOC_GPIO_PINS-1:0] pat;
        logic [`SOC_GPIO_PINS-1:0] out_mask;
        logic [`SOC_GPIO_PINS-1:0] in_mask;
        int                        t;
        start_test();
        rnd = next_random();
        pat = rnd[15:0];
        @(posedge clk);
        pin_pattern <= pat;
        // pin 0 output and pin 1 input at least
        rnd   = next_random();
        ctrl  = {rnd[31:4], 4'b1001};
        wdata = next_random();
        for (int i = 0; i < `SOC_GPIO_PINS; i++) begin
            out_mask[i] = (ctrl[2*i +: 2] == 2'b01);
            in_mask[i]  = (ctrl[2*i +: 2] == 2'b10);
        end
        bus_write(1'b0, addr_of(`SOC_GPIO_BASE, GPIO_CTRL), ctrl, t);
        bus_write(1'b0, addr_of(`SOC_GPIO_BASE, GPIO_DATA), wdata, t);
        @(negedge clk);
        check_value("gpio_oe_o", {16'h0, out_mask}, {16'h0, gpio_oe});
        check_value("gpio_o", {16'h0, wdata[15:0] & out_mask}, {16'h0, gpio_out & out_mask});
        bus_read(1'b1, addr_of(`SOC_GPIO_BASE, GPIO_DATA), d);
        check_value("gpio data", {16'h0, (wdata[15:0] & ~in_mask) | (pat & in_mask)}, d);
        finish_test("gpio_loopback");
    endtask

    // --------------------------------------------------
    // sequence and watchdog
    // --------------------------------------------------
    initial begin
        core_req    = '0;
        dbg_req     = '0;
        pin_pattern = '0;
        wait (rst_n === 1'b1);
        reset_state();
        ram_write_read();
        arbitration_hold();
        unmapped_region();
        timer_irq();
        gpio_loopback();
        $display("summary: %0d tests, %0d failed, %0d failed checks",
                 tests_run, tests_failed, fail_count);
        if (fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 20);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
